//--- bert_macros.svh
`ifndef BERT_MACROS_SVH
`define BERT_MACROS_SVH

// Counter width, also the host data width
`define BERT_CNT_W 32

// Bit memory entries, one transmitted bit each
`define BERT_MEM_DEPTH 256

// Loopback offset in bit periods
`define BERT_OFS_W 8

// Bit-period divider width in clocks
`define BERT_DIV_W 8

`endif

//--- bert_pkg.sv
`default_nettype none

`include "bert_macros.svh"

package bert_pkg;

    // Run state codes
    // WAITING is all zeros so an idle tester reads back as 0
    typedef enum logic [2:0] {
        WAITING  = 3'b000,
        DONE     = 3'b001,
        RUNNING  = 3'b010,
        IN_RESET = 3'b100
    } run_state_t;

    // Clocks per transmitted bit after reset
    localparam logic [`BERT_DIV_W-1:0] BERT_DIV_DEFAULT = 8;

endpackage

`default_nettype wire

//--- bert_reg_pkg.sv
`default_nettype none

package bert_reg_pkg;

    // Host register addresses
    typedef enum logic [3:0] {
        CTRL   = 4'd0,
        STATUS = 4'd1,
        OFFSET = 4'd2,
        BUDGET = 4'd3,
        DIV    = 4'd4,
        GOOD   = 4'd5,
        BAD    = 4'd6,
        TOTAL  = 4'd7
    } reg_addr_t;

    // Command bits in a CTRL write
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_STOP_BIT  = 1;

endpackage

`default_nettype wire

//--- bert_regs.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

module bert_regs (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    reg_wr,
    input  wire logic                    reg_rd,
    input  wire bert_reg_pkg::reg_addr_t reg_addr,
    input  wire logic [`BERT_CNT_W-1:0]  reg_wdata,
    output logic [`BERT_CNT_W-1:0]       reg_rdata,
    output logic                         reg_rvalid,
    output logic                         start_pulse,
    output logic                         stop_pulse,
    output logic [`BERT_OFS_W-1:0]       offset,
    output logic [`BERT_CNT_W-1:0]       budget,
    output logic [`BERT_DIV_W-1:0]       bit_div,
    bert_stats_if.regs                   stats
);
    import bert_pkg::*;
    import bert_reg_pkg::*;

    localparam int DATA_W = `BERT_CNT_W;

    // Shortest bit period the checker pipeline can follow
    localparam logic [`BERT_DIV_W-1:0] DIV_MIN = 4;

    logic [`BERT_DIV_W-1:0] div_wdata;
    logic                   ctrl_wr;
    logic [DATA_W-1:0]      rd_mux;

    assign div_wdata = reg_wdata[`BERT_DIV_W-1:0];
    assign ctrl_wr   = reg_wr && (reg_addr == CTRL);

    // CTRL is write-only, each bit a one-cycle command
    always_ff @(posedge clk) begin
        if (rst) begin
            start_pulse <= 1'b0;
            stop_pulse  <= 1'b0;
        end else begin
            start_pulse <= ctrl_wr && reg_wdata[CTRL_START_BIT];
            stop_pulse  <= ctrl_wr && reg_wdata[CTRL_STOP_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            offset  <= '0;
            budget  <= '0;
            bit_div <= BERT_DIV_DEFAULT;
        end else if (reg_wr) begin
            case (reg_addr)
                OFFSET: offset <= reg_wdata[`BERT_OFS_W-1:0];
                BUDGET: budget <= reg_wdata;
                DIV:    bit_div <= (div_wdata < DIV_MIN) ? DIV_MIN : div_wdata;
                default: begin
                end
            endcase
        end
    end

    // Unused addresses and CTRL read as zero
    always_comb begin
        case (reg_addr)
            STATUS:  rd_mux = DATA_W'(stats.run_state);
            OFFSET:  rd_mux = DATA_W'(offset);
            BUDGET:  rd_mux = budget;
            DIV:     rd_mux = DATA_W'(bit_div);
            GOOD:    rd_mux = stats.good_bits;
            BAD:     rd_mux = stats.bad_bits;
            TOTAL:   rd_mux = stats.total_bits;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    assert property (@(posedge clk) disable iff (rst) reg_rvalid |-> $past(reg_rd))
        else $error("reg_rvalid without a read one cycle earlier");

endmodule

`default_nettype wire

//--- bert_stats_if.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

interface bert_stats_if;
    import bert_pkg::*;

    run_state_t               run_state;
    logic [`BERT_CNT_W-1:0]   good_bits;
    logic [`BERT_CNT_W-1:0]   bad_bits;
    logic [`BERT_CNT_W-1:0]   total_bits;

    // Run controller owns the state and watches the bit budget
    modport ctrl (
        output run_state,
        input  total_bits
    );

    // Loopback checker counts only while running
    modport chk (
        input  run_state,
        output good_bits,
        output bad_bits,
        output total_bits
    );

    modport regs (
        input run_state,
        input good_bits,
        input bad_bits,
        input total_bits
    );

endinterface

`default_nettype wire

//--- bert_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

module bert_top (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    output logic                                          out_tx,
    output logic                                          cke_tx,
    input  wire logic                                     out_rx,
    input  wire logic                                     cke_rx,
    input  wire logic                                     reg_wr,
    input  wire logic                                     reg_rd,
    input  wire logic [$bits(bert_reg_pkg::reg_addr_t)-1:0] reg_addr,
    input  wire logic [`BERT_CNT_W-1:0]                   reg_wdata,
    output logic [`BERT_CNT_W-1:0]                        reg_rdata,
    output logic                                          reg_rvalid
);
    import bert_reg_pkg::*;

    logic                   start_pulse;
    logic                   stop_pulse;
    logic [`BERT_OFS_W-1:0] offset;
    logic [`BERT_CNT_W-1:0] budget;
    logic [`BERT_DIV_W-1:0] bit_div;
    reg_addr_t              host_addr;

    bert_stats_if stats_if ();

    // Host address arrives as plain bits
    assign host_addr = reg_addr_t'(reg_addr);

    prbs_tx_source prbs_tx_source_inst (
        .clk     (clk),
        .rst     (rst),
        .bit_div (bit_div),
        .tx_bit  (out_tx),
        .tx_cke  (cke_tx)
    );

    run_controller run_controller_inst (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .budget      (budget),
        .stats       (stats_if.ctrl)
    );

    // Checker sees the transmit side before it leaves the chip
    loopback_checker loopback_checker_inst (
        .clk    (clk),
        .rst    (rst),
        .tx_bit (out_tx),
        .tx_cke (cke_tx),
        .rx_bit (out_rx),
        .rx_cke (cke_rx),
        .offset (offset),
        .stats  (stats_if.chk)
    );

    bert_regs bert_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (host_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .start_pulse (start_pulse),
        .stop_pulse  (stop_pulse),
        .offset      (offset),
        .budget      (budget),
        .bit_div     (bit_div),
        .stats       (stats_if.regs)
    );

endmodule

`default_nettype wire

//--- loopback_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

module loopback_checker (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   tx_bit,
    input  wire logic                   tx_cke,
    input  wire logic                   rx_bit,
    input  wire logic                   rx_cke,
    input  wire logic [`BERT_OFS_W-1:0] offset,
    bert_stats_if.chk                   stats
);
    import bert_pkg::*;

    localparam int ADDR_W = $clog2(`BERT_MEM_DEPTH);

    logic              tx_cke_d;
    logic              rx_cke_d;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              mem [0:`BERT_MEM_DEPTH-1];
    logic              mem_bit;
    logic              count_en;
    logic              bit_ok;

    // Strobes one cycle late so the stored bit is read out in time
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_cke_d <= 1'b0;
            rx_cke_d <= 1'b0;
        end else begin
            tx_cke_d <= tx_cke;
            rx_cke_d <= rx_cke;
        end
    end

    // One entry per transmitted bit
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (tx_cke_d) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // Offset counts bit periods, which is memory entries
    assign rd_addr = wr_addr - ADDR_W'(offset);

    always_ff @(posedge clk) begin
        if (tx_cke_d) begin
            mem[wr_addr] <= tx_bit;
        end
    end

    // Read latency of one
    always_ff @(posedge clk) begin
        mem_bit <= mem[rd_addr];
    end

    assign count_en = (stats.run_state == RUNNING) && rx_cke_d;
    assign bit_ok   = (mem_bit == rx_bit);

    // Counters clear in the start cycle of each run
    always_ff @(posedge clk) begin
        if (rst || (stats.run_state == IN_RESET)) begin
            stats.good_bits  <= '0;
            stats.bad_bits   <= '0;
            stats.total_bits <= '0;
        end else if (count_en) begin
            stats.total_bits <= stats.total_bits + 1'b1;
            if (bit_ok) begin
                stats.good_bits <= stats.good_bits + 1'b1;
            end else begin
                stats.bad_bits <= stats.bad_bits + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $changed(stats.total_bits)
        |=> (stats.good_bits + stats.bad_bits == stats.total_bits))
        else $error("good %0d + bad %0d != total %0d",
                    stats.good_bits, stats.bad_bits, stats.total_bits);

endmodule

`default_nettype wire

//--- prbs_tx_source.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

module prbs_tx_source (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`BERT_DIV_W-1:0] bit_div,
    output logic                        tx_bit,
    output logic                        tx_cke
);
    import bert_pkg::*;

    logic [`BERT_DIV_W-1:0] div_cnt;
    logic [6:0]             lfsr;
    logic                   wrap;

    assign wrap = (div_cnt == '0);

    // Down-counter, a new bit_div is only picked up on reload
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= BERT_DIV_DEFAULT - 1'b1;
            tx_cke  <= 1'b0;
        end else if (wrap) begin
            div_cnt <= bit_div - 1'b1;
            tx_cke  <= 1'b1;
        end else begin
            div_cnt <= div_cnt - 1'b1;
            tx_cke  <= 1'b0;
        end
    end

    // PRBS7, x^7 + x^6 + 1
    // Steps on the same edge that raises tx_cke
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= '1;
        end else if (wrap) begin
            lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
        end
    end

    // Held for the whole bit period
    assign tx_bit = lfsr[6];

    // Relies on the register block never handing out a period below 4
    assert property (@(posedge clk) disable iff (rst) tx_cke |=> !tx_cke)
        else $error("tx_cke high in two consecutive cycles");

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bert_pkg.sv
bert_reg_pkg.sv
bert_stats_if.sv
prbs_tx_source.sv
run_controller.sv
loopback_checker.sv
bert_regs.sv
bert_top.sv
tb_bert.sv

//--- run.sh
#!/bin/sh
# Compile and run the BERT testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    -f project.f \
    --top-module tb_bert \
    -o tb_bert

./obj_dir/tb_bert > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- run_controller.sv
`default_nettype none
`timescale 1ns/100ps

`include "bert_macros.svh"

module run_controller (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start_pulse,
    input  wire logic                   stop_pulse,
    input  wire logic [`BERT_CNT_W-1:0] budget,
    bert_stats_if.ctrl                  stats
);
    import bert_pkg::*;

    // Set when IN_RESET was entered from a start command
    logic start_armed;
    logic budget_hit;

    // Zero budget runs until stopped
    assign budget_hit = (budget != '0) && (stats.total_bits >= budget);

    always_ff @(posedge clk) begin
        if (rst) begin
            stats.run_state <= IN_RESET;
            start_armed     <= 1'b0;
        end else begin
            case (stats.run_state)
                // Single cycle, the checker clears its counters here
                IN_RESET: begin
                    stats.run_state <= start_armed ? RUNNING : WAITING;
                    start_armed     <= 1'b0;
                end
                WAITING, DONE: begin
                    if (start_pulse) begin
                        stats.run_state <= IN_RESET;
                        start_armed     <= 1'b1;
                    end
                end
                RUNNING: begin
                    if (stop_pulse || budget_hit) begin
                        stats.run_state <= DONE;
                    end
                end
                default: begin
                    stats.run_state <= IN_RESET;
                    start_armed     <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        stats.run_state inside {IN_RESET, WAITING, RUNNING, DONE})
        else $error("illegal run state %b", stats.run_state);

endmodule

`default_nettype wire

//--- tb_bert.sv
`timescale 1ns/100ps
`default_nettype none

`include "bert_macros.svh"

module tb_bert;
    import bert_pkg::*;
    import bert_reg_pkg::*;

    // Loopback delay of the channel model in strobes
    localparam int LOOP_DELAY     = 40;
    localparam int RUN_BUDGET     = 500;
    localparam int BIT_PERIOD     = 8;
    localparam int STOP_STROBES   = 100;
    localparam int NUM_FLIPS      = 6;
    localparam int TIMEOUT_CYCLES =
        (3 * RUN_BUDGET + STOP_STROBES) * BIT_PERIOD * 2 + 2000;

    logic                   clk;
    logic                   rst;
    logic                   out_tx;
    logic                   cke_tx;
    logic                   out_rx = 1'b0;
    logic                   cke_rx = 1'b0;
    logic                   reg_wr;
    logic                   reg_rd;
    logic [3:0]             reg_addr;
    logic [`BERT_CNT_W-1:0] reg_wdata;
    logic [`BERT_CNT_W-1:0] reg_rdata;
    logic                   reg_rvalid;

    logic [63:0] tx_hist = '0;
    logic        flip_mask [0:511];
    int          rx_cnt = 0;
    int          cycle_count = 0;
    int          error_count;
    int          check_count;
    logic [31:0] rand_state;

    // Expected PRBS7 shift register, stage 7 is the line output
    logic        prbs_stage [1:7];

    bert_top bert_top_inst (
        .clk        (clk),
        .rst        (rst),
        .out_tx     (out_tx),
        .cke_tx     (cke_tx),
        .out_rx     (out_rx),
        .cke_rx     (cke_rx),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic flip_at(input int idx);
        return (idx < 512) ? flip_mask[idx] : 1'b0;
    endfunction

    // Channel model, returns the bit sent LOOP_DELAY strobes earlier
    always @(negedge clk) begin
        if (cke_tx) begin
            tx_hist = {tx_hist[62:0], out_tx};
            cke_rx <= 1'b1;
            out_rx <= tx_hist[LOOP_DELAY] ^ flip_at(rx_cnt + 1);
        end else begin
            cke_rx <= 1'b0;
        end
    end

    // Rx strobes since the last start command
    always @(posedge clk) begin
        if (reg_wr && (reg_addr == CTRL) && reg_wdata[CTRL_START_BIT]) begin
            rx_cnt <= 0;
        end else if (cke_rx) begin
            rx_cnt <= rx_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], rand_state[0]};
            rand_state = rand_state[0] ? ((rand_state >> 1) ^ 32'h80200003)
                                       : (rand_state >> 1);
        end
        return value;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("[FAIL] %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // x^7 + x^6 + 1, feedback from stages 6 and 7 into stage 1
    task automatic step_prbs_model();
        logic feedback;
        feedback = prbs_stage[6] ^ prbs_stage[7];
        for (int i = 7; i > 1; i--) begin
            prbs_stage[i] = prbs_stage[i - 1];
        end
        prbs_stage[1] = feedback;
    endtask

    // Transmit line follows the model and holds between strobes
    always @(negedge clk) begin
        if (!rst) begin
            if (cke_tx) begin
                step_prbs_model();
            end
            compare_value("out_tx", out_tx, prbs_stage[7]);
        end
    end

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    // Data must come back exactly one cycle after the strobe
    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        compare_value("reg_rvalid before read", reg_rvalid, 0);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        compare_value("reg_rvalid", reg_rvalid, 1);
        data = reg_rdata;
    endtask

    task automatic wait_state(input run_state_t state);
        logic [31:0] value;
        reg_read(STATUS, value);
        while (value[2:0] !== state) begin
            reg_read(STATUS, value);
        end
    endtask

    task automatic wait_strobes(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (cke_tx) begin
                seen++;
            end
        end
    endtask

    task automatic run_to_done();
        reg_write(CTRL, 1 << CTRL_START_BIT);
        wait_state(RUNNING);
        wait_state(DONE);
        check_count++;
        assert (rx_cnt >= RUN_BUDGET) else begin
            error_count++;
            $display("%0t: the channel returned fewer strobes than the budget", $time);
        end
    endtask

    task automatic reset_defaults();
        logic [31:0] value;
        compare_value("cke_tx", cke_tx, 0);
        compare_value("reg_rvalid", reg_rvalid, 0);
        reg_read(GOOD, value);
        compare_value("GOOD", value, 0);
        reg_read(BAD, value);
        compare_value("BAD", value, 0);
        reg_read(TOTAL, value);
        compare_value("TOTAL", value, 0);
        reg_read(STATUS, value);
        compare_value("STATUS", value, WAITING);
        @(negedge clk);
        compare_value("reg_rvalid after read", reg_rvalid, 0);
    endtask

    task automatic clean_loopback();
        logic [31:0] value;
        reg_write(OFFSET, LOOP_DELAY);
        reg_write(BUDGET, RUN_BUDGET);
        // Let the bit memory fill first
        wait_strobes(300);
        run_to_done();
        reg_read(TOTAL, value);
        compare_value("TOTAL", value, RUN_BUDGET);
        reg_read(BAD, value);
        compare_value("BAD", value, 0);
        reg_read(GOOD, value);
        compare_value("GOOD", value, RUN_BUDGET);
    endtask

    task automatic injected_errors();
        logic [31:0] pos;
        logic [31:0] value;
        int          placed;
        int          tries;
        placed = 0;
        tries  = 0;
        // Flips stay inside strobes 10 to 490
        while ((placed < NUM_FLIPS) && (tries < 1000)) begin
            pos = take_bits(9);
            tries++;
            if ((pos >= 10) && (pos <= 490) && !flip_mask[pos]) begin
                flip_mask[pos] = 1'b1;
                placed++;
            end
        end
        run_to_done();
        reg_read(BAD, value);
        compare_value("BAD", value, placed);
        reg_read(GOOD, value);
        compare_value("GOOD", value, RUN_BUDGET - placed);
        for (int i = 0; i < 512; i++) begin
            flip_mask[i] = 1'b0;
        end
    endtask

    task automatic wrong_offset();
        logic [31:0] good;
        logic [31:0] bad;
        logic [31:0] total;
        reg_write(OFFSET, LOOP_DELAY + 1);
        run_to_done();
        reg_read(GOOD, good);
        reg_read(BAD, bad);
        reg_read(TOTAL, total);
        check_count++;
        assert (bad != 0) else begin
            error_count++;
            $display("[FAIL] %0t: BAD = %0d, expected nonzero", $time, bad);
        end
        compare_value("GOOD + BAD", good + bad, total);
        compare_value("TOTAL", total, RUN_BUDGET);
        reg_write(OFFSET, LOOP_DELAY);
    endtask

    task automatic stop_restart();
        logic [31:0] first;
        logic [31:0] second;
        reg_write(BUDGET, 0);
        reg_write(CTRL, 1 << CTRL_START_BIT);
        wait_state(RUNNING);
        while (rx_cnt < STOP_STROBES) begin
            @(negedge clk);
        end
        reg_write(CTRL, 1 << CTRL_STOP_BIT);
        wait_state(DONE);
        reg_read(TOTAL, first);
        wait_strobes(5);
        reg_read(TOTAL, second);
        compare_value("TOTAL after stop", second, first);
        reg_write(CTRL, 1 << CTRL_START_BIT);
        wait_state(RUNNING);
        reg_read(TOTAL, second);
        check_count++;
        assert (second < 10) else begin
            error_count++;
            $display("[FAIL] %0t: TOTAL = %0d, expected below 10", $time, second);
        end
        reg_write(CTRL, 1 << CTRL_STOP_BIT);
        wait_state(DONE);
    endtask

    task automatic bit_period();
        logic [31:0] value;
        int          gap;
        reg_write(DIV, 12);
        // New period starts at a wrap, so skip two pulses
        wait_strobes(2);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!cke_tx);
        compare_value("cke_tx spacing", gap, 12);
        reg_write(DIV, 2);
        reg_read(DIV, value);
        compare_value("DIV", value, 4);
    endtask

    initial begin
        rst         = 1'b1;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        error_count = 0;
        check_count = 0;
        rand_state  = 32'h9a64;
        for (int i = 0; i < 512; i++) begin
            flip_mask[i] = 1'b0;
        end
        // Seed is all ones
        for (int i = 1; i <= 7; i++) begin
            prbs_stage[i] = 1'b1;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        reset_defaults();
        clean_loopback();
        injected_errors();
        wrong_offset();
        stop_restart();
        bit_period();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
